//--- rab_pkg.sv
package rab_pkg;

  // request side and translated side address widths
  localparam int unsigned VADDR_WIDTH     = 32;
  localparam int unsigned PADDR_WIDTH     = 40;

  // slice configuration word
  localparam int unsigned CFG_DATA_WIDTH  = 64;

  // low address bits cleared by burst size on a 64-bit data bus
  localparam int unsigned SIZE_ALIGN_BITS = 3;

  // registers per slice in order start, end, offset and flags
  localparam int unsigned REGS_PER_SLICE  = 4;

  // bit positions inside the flags register
  localparam int unsigned FLAG_VALID      = 0;
  localparam int unsigned FLAG_READ       = 1;
  localparam int unsigned FLAG_WRITE      = 2;

  typedef logic [VADDR_WIDTH-1:0]    vaddr_t;
  typedef logic [PADDR_WIDTH-1:0]    paddr_t;
  typedef logic [CFG_DATA_WIDTH-1:0] cfg_word_t;

  typedef logic [7:0]                burst_len_t;   // axi len as beats minus one
  typedef logic [2:0]                burst_size_t;  // axi size as log2 bytes per beat

endpackage

//--- rab_lookup_if.sv
`timescale 1ns/1ps

interface rab_lookup_if
  import rab_pkg::*;
();

  logic   sel;       // high when port 1 is the active port
  logic   rw;        // high for a write
  vaddr_t addr_min;  // first byte of the burst
  vaddr_t addr_max;  // last byte of the burst

  logic   hit_any;
  logic   prot_any;
  logic   multi;
  paddr_t out_addr;

  modport arb    (output sel, rw, addr_min, addr_max);
  modport slices (input rw, addr_min, addr_max, output hit_any, prot_any, multi, out_addr);
  modport fsm    (input sel, hit_any, prot_any, multi, out_addr);

endinterface

//--- rab_cfg_regs.sv
`timescale 1ns/1ps

module rab_cfg_regs
  import rab_pkg::*;
#(
  parameter int N_SLICES = 4
)
(
  input  logic                                         Clk_CI,
  input  logic                                         Rst_RBI,

  input  logic                                         cfg_wen,
  input  logic [$clog2(REGS_PER_SLICE*N_SLICES)-1:0]   cfg_addr,
  input  cfg_word_t                                    cfg_wdata,

  output cfg_word_t [REGS_PER_SLICE*N_SLICES-1:0]      cfg_regs
);

  localparam int N_REGS = REGS_PER_SLICE * N_SLICES;

  logic addr_in_range;

  // index space is a power of two, so some indices may have no register
  assign addr_in_range = (int'(cfg_addr) < N_REGS);

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      cfg_regs <= '0;  // all flags clear so every slice starts invalid
    end
    else if (cfg_wen && addr_in_range)
    begin
      cfg_regs[cfg_addr] <= cfg_wdata;
    end
  end

endmodule

//--- rab_slice.sv
`timescale 1ns/1ps

module rab_slice
  import rab_pkg::*;
(
  input  cfg_word_t cfg_start,
  input  cfg_word_t cfg_end,
  input  cfg_word_t cfg_offset,
  input  cfg_word_t cfg_flags,

  input  logic      rw,
  input  vaddr_t    addr_min,
  input  vaddr_t    addr_max,

  output logic      hit,
  output logic      prot,
  output paddr_t    out_addr
);

  vaddr_t start_addr;
  vaddr_t end_addr;
  paddr_t phys_offset;
  vaddr_t rel_addr;
  logic   perm_ok;

  // only the low bits of the config words carry an address
  assign start_addr  = cfg_start[VADDR_WIDTH-1:0];
  assign end_addr    = cfg_end[VADDR_WIDTH-1:0];
  assign phys_offset = cfg_offset[PADDR_WIDTH-1:0];

  // whole burst must lie inside [start, end]
  assign hit = cfg_flags[FLAG_VALID] && (start_addr <= addr_min) && (addr_max <= end_addr);

  assign perm_ok = rw ? cfg_flags[FLAG_WRITE] : cfg_flags[FLAG_READ];
  assign prot    = hit & ~perm_ok;

  // translation is meaningful only on a hit
  assign rel_addr = addr_min - start_addr;
  assign out_addr = {{(PADDR_WIDTH-VADDR_WIDTH){1'b0}}, rel_addr} + phys_offset;

endmodule

//--- rab_slice_array.sv
`timescale 1ns/1ps

module rab_slice_array
  import rab_pkg::*;
#(
  parameter int N_SLICES = 4
)
(
  input  cfg_word_t [REGS_PER_SLICE*N_SLICES-1:0] cfg_regs,
  rab_lookup_if.slices                            lookup
);

  logic [N_SLICES-1:0] hit;
  logic [N_SLICES-1:0] prot;
  paddr_t              slice_addr [N_SLICES];
  paddr_t              sel_addr;

  for (genvar i = 0; i < N_SLICES; i++)
  begin : g_slice
    rab_slice u_slice (
      .cfg_start  (cfg_regs[REGS_PER_SLICE*i]),
      .cfg_end    (cfg_regs[REGS_PER_SLICE*i+1]),
      .cfg_offset (cfg_regs[REGS_PER_SLICE*i+2]),
      .cfg_flags  (cfg_regs[REGS_PER_SLICE*i+3]),
      .rw         (lookup.rw),
      .addr_min   (lookup.addr_min),
      .addr_max   (lookup.addr_max),
      .hit        (hit[i]),
      .prot       (prot[i]),
      .out_addr   (slice_addr[i])
    );
  end

  assign lookup.hit_any  = |hit;
  assign lookup.prot_any = |prot;
  assign lookup.multi    = |(hit & (hit - 1'b1));  // more than one bit set

  // lowest-numbered hit wins, so scan downwards
  always_comb
  begin
    sel_addr = '0;
    for (int i = N_SLICES-1; i >= 0; i--)
    begin
      if (hit[i])
      begin
        sel_addr = slice_addr[i];
      end
    end
  end

  assign lookup.out_addr = sel_addr;

endmodule

//--- rab_req_arbiter.sv
`timescale 1ns/1ps

module rab_req_arbiter
  import rab_pkg::*;
(
  input  logic        Clk_CI,
  input  logic        Rst_RBI,

  input  vaddr_t      port1_addr,
  input  burst_len_t  port1_len,
  input  burst_size_t port1_size,
  input  logic        port1_type,
  input  logic        port1_addr_valid,

  input  vaddr_t      port2_addr,
  input  burst_len_t  port2_len,
  input  burst_size_t port2_size,
  input  logic        port2_type,
  input  logic        port2_addr_valid,

  input  logic        port1_done,
  input  logic        port2_done,

  rab_lookup_if.arb   lookup
);

  logic   last_p1;  // port 1 was served last
  logic   sel;
  vaddr_t p1_max_addr;
  vaddr_t p2_max_addr;

  // last byte touched by a burst
  function automatic vaddr_t burst_end(input vaddr_t      addr,
                                       input burst_len_t  len,
                                       input burst_size_t size);
    vaddr_t                     aligned;
    vaddr_t                     n_bytes;
    logic [SIZE_ALIGN_BITS-1:0] mask;
    mask = {SIZE_ALIGN_BITS{1'b1}};
    if (size <= burst_size_t'(SIZE_ALIGN_BITS))
    begin
      mask = {SIZE_ALIGN_BITS{1'b1}} << size;  // size 0 keeps all bits
    end
    aligned = addr;
    aligned[SIZE_ALIGN_BITS-1:0] = addr[SIZE_ALIGN_BITS-1:0] & mask;
    n_bytes = (vaddr_t'(len) + vaddr_t'(1)) << size;
    return aligned + n_bytes - vaddr_t'(1);
  endfunction

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      last_p1 <= 1'b0;  // port 2 takes the first tie
    end
    else if (port1_done)
    begin
      last_p1 <= 1'b1;
    end
    else if (port2_done)
    begin
      last_p1 <= 1'b0;
    end
  end

  assign sel         = (last_p1 & port1_addr_valid) | ~port2_addr_valid;
  assign p1_max_addr = burst_end(port1_addr, port1_len, port1_size);
  assign p2_max_addr = burst_end(port2_addr, port2_len, port2_size);

  assign lookup.sel      = sel;
  assign lookup.rw       = sel ? port1_type  : port2_type;
  assign lookup.addr_min = sel ? port1_addr  : port2_addr;
  assign lookup.addr_max = sel ? p1_max_addr : p2_max_addr;

endmodule

//--- rab_fsm.sv
`timescale 1ns/1ps

module rab_fsm
  import rab_pkg::*;
(
  input  logic       Clk_CI,
  input  logic       Rst_RBI,

  input  logic       port1_addr_valid,
  input  logic       port2_addr_valid,
  input  logic       port1_sent,
  input  logic       port2_sent,

  rab_lookup_if.fsm  lookup,

  output logic       port1_accept,
  output logic       port1_drop,
  output logic       port2_accept,
  output logic       port2_drop,
  output paddr_t     out_addr,

  output logic       int_miss,
  output logic       int_prot,
  output logic       int_multi
);

  typedef enum logic [1:0] {
    IDLE,
    RESULT,
    WAIT_SENT
  } rab_state_e;

  rab_state_e state;
  logic       sel_q;  // port captured at lookup
  logic       accept_c;
  logic       miss_c;
  logic       prot_c;
  logic       multi_c;
  logic       sent_sel;

  // drop causes where multi-hit masks protection
  assign miss_c   = ~lookup.hit_any;
  assign multi_c  = lookup.multi;
  assign prot_c   = lookup.hit_any & ~lookup.multi & lookup.prot_any;
  assign accept_c = lookup.hit_any & ~lookup.multi & ~lookup.prot_any;

  assign sent_sel = sel_q ? port1_sent : port2_sent;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      state        <= IDLE;
      sel_q        <= 1'b0;
      out_addr     <= '0;
      port1_accept <= 1'b0;
      port1_drop   <= 1'b0;
      port2_accept <= 1'b0;
      port2_drop   <= 1'b0;
      int_miss     <= 1'b0;
      int_prot     <= 1'b0;
      int_multi    <= 1'b0;
    end
    else
    begin
      // decision outputs are single-cycle pulses
      port1_accept <= 1'b0;
      port1_drop   <= 1'b0;
      port2_accept <= 1'b0;
      port2_drop   <= 1'b0;
      int_miss     <= 1'b0;
      int_prot     <= 1'b0;
      int_multi    <= 1'b0;

      case (state)
        IDLE:
        begin
          if (port1_addr_valid || port2_addr_valid)
          begin
            sel_q        <= lookup.sel;
            out_addr     <= lookup.out_addr;
            port1_accept <= lookup.sel & accept_c;
            port1_drop   <= lookup.sel & ~accept_c;
            port2_accept <= ~lookup.sel & accept_c;
            port2_drop   <= ~lookup.sel & ~accept_c;
            int_miss     <= miss_c;
            int_prot     <= prot_c;
            int_multi    <= multi_c;
            state        <= RESULT;
          end
        end
        RESULT:
        begin
          // accepted burst holds the lookup until it is forwarded
          state <= (port1_accept || port2_accept) ? WAIT_SENT : IDLE;
        end
        WAIT_SENT:
        begin
          if (sent_sel)
          begin
            state <= IDLE;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

//--- rab_core.sv
`timescale 1ns/1ps

module rab_core
  import rab_pkg::*;
#(
  parameter int N_SLICES = 4
)
(
  input  logic                                       Clk_CI,
  input  logic                                       Rst_RBI,

  input  vaddr_t                                     port1_addr,
  input  burst_len_t                                 port1_len,
  input  burst_size_t                                port1_size,
  input  logic                                       port1_type,
  input  logic                                       port1_addr_valid,
  input  logic                                       port1_sent,
  output logic                                       port1_accept,
  output logic                                       port1_drop,
  output paddr_t                                     port1_out_addr,

  input  vaddr_t                                     port2_addr,
  input  burst_len_t                                 port2_len,
  input  burst_size_t                                port2_size,
  input  logic                                       port2_type,
  input  logic                                       port2_addr_valid,
  input  logic                                       port2_sent,
  output logic                                       port2_accept,
  output logic                                       port2_drop,
  output paddr_t                                     port2_out_addr,

  input  logic                                       cfg_wen,
  input  logic [$clog2(REGS_PER_SLICE*N_SLICES)-1:0] cfg_addr,
  input  cfg_word_t                                  cfg_wdata,

  output logic                                       int_miss,
  output logic                                       int_prot,
  output logic                                       int_multi
);

  cfg_word_t [REGS_PER_SLICE*N_SLICES-1:0] cfg_regs;
  paddr_t                                  out_addr;
  logic                                    port1_done;
  logic                                    port2_done;

  rab_lookup_if lookup_if ();

  assign port1_done     = port1_accept | port1_drop;
  assign port2_done     = port2_accept | port2_drop;
  assign port1_out_addr = out_addr;  // one lookup result shared by both ports
  assign port2_out_addr = out_addr;

  rab_cfg_regs #(.N_SLICES(N_SLICES)) u_cfg_regs (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .cfg_wen   (cfg_wen),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_regs  (cfg_regs)
  );

  rab_req_arbiter u_req_arbiter (
    .Clk_CI           (Clk_CI),
    .Rst_RBI          (Rst_RBI),
    .port1_addr       (port1_addr),
    .port1_len        (port1_len),
    .port1_size       (port1_size),
    .port1_type       (port1_type),
    .port1_addr_valid (port1_addr_valid),
    .port2_addr       (port2_addr),
    .port2_len        (port2_len),
    .port2_size       (port2_size),
    .port2_type       (port2_type),
    .port2_addr_valid (port2_addr_valid),
    .port1_done       (port1_done),
    .port2_done       (port2_done),
    .lookup           (lookup_if)
  );

  rab_slice_array #(.N_SLICES(N_SLICES)) u_slice_array (
    .cfg_regs (cfg_regs),
    .lookup   (lookup_if)
  );

  rab_fsm u_fsm (
    .Clk_CI           (Clk_CI),
    .Rst_RBI          (Rst_RBI),
    .port1_addr_valid (port1_addr_valid),
    .port2_addr_valid (port2_addr_valid),
    .port1_sent       (port1_sent),
    .port2_sent       (port2_sent),
    .lookup           (lookup_if),
    .port1_accept     (port1_accept),
    .port1_drop       (port1_drop),
    .port2_accept     (port2_accept),
    .port2_drop       (port2_drop),
    .out_addr         (out_addr),
    .int_miss         (int_miss),
    .int_prot         (int_prot),
    .int_multi        (int_multi)
  );

endmodule

//--- tb_rab_core.sv
`timescale 1ns/1ps

module tb_rab_core
  import rab_pkg::*;
();

  localparam int N_SLICES    = 4;
  localparam int CFG_AW      = $clog2(REGS_PER_SLICE * N_SLICES);
  localparam int N_TESTS     = 15;
  localparam int CYCLE_LIMIT = N_TESTS * 30 + 200;

  localparam int IRQ_NONE  = 0;
  localparam int IRQ_MISS  = 1;
  localparam int IRQ_PROT  = 2;
  localparam int IRQ_MULTI = 3;

  typedef struct {
    int valid;
    int addr;
    int len;
    int size;
    int wr;
  } req_t;

  typedef struct {
    req_t p1;
    req_t p2;
    int   sent_low;  // cycles sent stays low after an accept
    int   exp_port;
    int   exp_acc;
    int   exp_slice;
    int   exp_irq;
    int   rnd;       // random 8-byte step added to both addresses
  } test_t;

  logic                Clk_CI = 1'b0;
  logic                Rst_RBI;
  vaddr_t              port1_addr, port2_addr;
  burst_len_t          port1_len, port2_len;
  burst_size_t         port1_size, port2_size;
  logic                port1_type, port1_addr_valid, port1_sent;
  logic                port2_type, port2_addr_valid, port2_sent;
  logic                port1_accept, port1_drop, port2_accept, port2_drop;
  paddr_t              port1_out_addr, port2_out_addr;
  logic                cfg_wen;
  logic [CFG_AW-1:0]   cfg_addr;
  cfg_word_t           cfg_wdata;
  logic                int_miss, int_prot, int_multi;

  // slice 0 rw, slice 1 read-only and slices 2 and 3 overlapping from 0x8800
  vaddr_t slice_start  [N_SLICES] = '{32'h1000, 32'h4000, 32'h8000, 32'h8800};
  vaddr_t slice_end    [N_SLICES] = '{32'h1fff, 32'h4fff, 32'h8fff, 32'h9fff};
  paddr_t slice_offset [N_SLICES] = '{40'h10_0000_0000, 40'h00_2000_0000,
                                      40'h03_0000_0000, 40'h04_0000_8000};
  logic   slice_wr_ok  [N_SLICES] = '{1'b1, 1'b0, 1'b1, 1'b1};

  req_t   idle_req = '{0, 0, 0, 0, 0};
  test_t  tests [N_TESTS];
  int     err_count    = 0;
  int     tests_failed = 0;
  int     cycles       = 0;

  rab_core #(.N_SLICES(N_SLICES)) dut_i (
    .Clk_CI           (Clk_CI),
    .Rst_RBI          (Rst_RBI),
    .port1_addr       (port1_addr),
    .port1_len        (port1_len),
    .port1_size       (port1_size),
    .port1_type       (port1_type),
    .port1_addr_valid (port1_addr_valid),
    .port1_sent       (port1_sent),
    .port1_accept     (port1_accept),
    .port1_drop       (port1_drop),
    .port1_out_addr   (port1_out_addr),
    .port2_addr       (port2_addr),
    .port2_len        (port2_len),
    .port2_size       (port2_size),
    .port2_type       (port2_type),
    .port2_addr_valid (port2_addr_valid),
    .port2_sent       (port2_sent),
    .port2_accept     (port2_accept),
    .port2_drop       (port2_drop),
    .port2_out_addr   (port2_out_addr),
    .cfg_wen          (cfg_wen),
    .cfg_addr         (cfg_addr),
    .cfg_wdata        (cfg_wdata),
    .int_miss         (int_miss),
    .int_prot         (int_prot),
    .int_multi        (int_multi)
  );

  always #5 Clk_CI = ~Clk_CI;

  always @(posedge Clk_CI)
  begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      err_count++;
    end
  endtask

  function automatic int pulse_count();
    return int'(port1_accept) + int'(port1_drop) + int'(port2_accept) + int'(port2_drop);
  endfunction

  task automatic load_slices();
    cfg_word_t vals [REGS_PER_SLICE];
    for (int s = 0; s < N_SLICES; s++)
    begin
      vals[0] = cfg_word_t'(slice_start[s]);
      vals[1] = cfg_word_t'(slice_end[s]);
      vals[2] = cfg_word_t'(slice_offset[s]);
      vals[3] = '0;
      vals[3][FLAG_VALID] = 1'b1;
      vals[3][FLAG_READ]  = 1'b1;
      vals[3][FLAG_WRITE] = slice_wr_ok[s];
      for (int r = 0; r < REGS_PER_SLICE; r++)
      begin
        @(negedge Clk_CI);
        cfg_wen   = 1'b1;
        cfg_addr  = CFG_AW'(s * REGS_PER_SLICE + r);
        cfg_wdata = vals[r];
      end
    end
    @(negedge Clk_CI);
    cfg_wen = 1'b0;
  endtask

  task automatic build_table();
    //                port 1 valid addr len size wr     port 2       low port acc slc irq rnd
    tests[0]  = '{'{1, 'h1100, 0, 2, 0}, '{1, 'h1100, 0, 2, 0}, 0, 2, 0, 0, IRQ_MISS, 0};
    tests[1]  = '{'{1, 'h1100, 0, 2, 0}, '{1, 'h9100, 0, 2, 0}, 3, 2, 1, 3, IRQ_NONE, 1};
    tests[2]  = '{'{1, 'h1100, 0, 2, 0}, idle_req, 0, 1, 1, 0, IRQ_NONE, 1};
    tests[3]  = '{'{1, 'h1800, 0, 2, 1}, '{1, 'h9800, 0, 2, 0}, 2, 1, 1, 0, IRQ_NONE, 0};
    tests[4]  = '{idle_req, '{1, 'h9a00, 0, 2, 1}, 1, 2, 1, 3, IRQ_NONE, 0};
    tests[5]  = '{'{1, 'h4100, 0, 2, 0}, '{1, 'h1200, 0, 2, 0}, 4, 2, 1, 0, IRQ_NONE, 0};
    tests[6]  = '{'{1, 'h3000, 0, 2, 0}, idle_req, 0, 1, 0, 0, IRQ_MISS, 0};
    tests[7]  = '{'{1, 'h4100, 0, 2, 1}, idle_req, 0, 1, 0, 0, IRQ_PROT, 0};
    tests[8]  = '{'{1, 'h4100, 0, 2, 0}, idle_req, 0, 1, 1, 1, IRQ_NONE, 1};
    tests[9]  = '{idle_req, '{1, 'h8900, 0, 2, 0}, 0, 2, 0, 0, IRQ_MULTI, 0};
    tests[10] = '{'{1, 'h1f80, 16, 3, 0}, idle_req, 0, 1, 0, 0, IRQ_MISS, 0};  // ends at 0x2007
    tests[11] = '{'{1, 'h1f80, 15, 3, 0}, idle_req, 1, 1, 1, 0, IRQ_NONE, 0};
    tests[12] = '{idle_req, '{1, 'h1ffc, 0, 3, 1}, 0, 2, 1, 0, IRQ_NONE, 0};   // aligned down
    tests[13] = '{idle_req, '{1, 'h1ffe, 2, 0, 0}, 0, 2, 0, 0, IRQ_MISS, 0};   // size 0 unmasked
    tests[14] = '{idle_req, '{1, 'h1ffe, 1, 0, 0}, 2, 2, 1, 0, IRQ_NONE, 0};
  endtask

  task automatic run_test(input int idx);
    test_t  t;
    req_t   served;
    int     off;
    int     got_port;
    int     errs_before;
    paddr_t got_addr;
    paddr_t exp_addr;
    t = tests[idx];
    errs_before = err_count;
    if (t.rnd != 0)
    begin
      off = int'($urandom % 128) * 8;
      t.p1.addr += off;
      t.p2.addr += off;
    end
    @(negedge Clk_CI);
    port1_addr_valid = t.p1.valid[0];
    port1_addr       = vaddr_t'(t.p1.addr);
    port1_len        = burst_len_t'(t.p1.len);
    port1_size       = burst_size_t'(t.p1.size);
    port1_type       = t.p1.wr[0];
    port2_addr_valid = t.p2.valid[0];
    port2_addr       = vaddr_t'(t.p2.addr);
    port2_len        = burst_len_t'(t.p2.len);
    port2_size       = burst_size_t'(t.p2.size);
    port2_type       = t.p2.wr[0];
    @(negedge Clk_CI);
    while (pulse_count() == 0)
    begin
      @(negedge Clk_CI);
    end
    got_port = (port1_accept || port1_drop) ? 1 : 2;
    got_addr = (got_port == 1) ? port1_out_addr : port2_out_addr;
    if (t.exp_port == 1)
    begin
      served = t.p1;
    end
    else
    begin
      served = t.p2;
    end
    check_value("decision count", 64'(pulse_count()), 64'(1));
    check_value("served port", 64'(got_port), 64'(t.exp_port));
    check_value("accept", 64'(port1_accept | port2_accept), 64'(t.exp_acc));
    check_value("int_miss", 64'(int_miss), 64'(t.exp_irq == IRQ_MISS));
    check_value("int_prot", 64'(int_prot), 64'(t.exp_irq == IRQ_PROT));
    check_value("int_multi", 64'(int_multi), 64'(t.exp_irq == IRQ_MULTI));
    if (t.exp_acc != 0)
    begin
      // request address minus slice start plus slice offset
      exp_addr = paddr_t'(vaddr_t'(served.addr) - slice_start[t.exp_slice])
               + slice_offset[t.exp_slice];
      check_value("out_addr", 64'(got_addr), 64'(exp_addr));
    end
    if (port1_accept || port2_accept)
    begin
      // served port lets go while the other one keeps asking
      if (got_port == 1)
      begin
        port1_addr_valid = 1'b0;
      end
      else
      begin
        port2_addr_valid = 1'b0;
      end
      repeat (t.sent_low)
      begin
        @(negedge Clk_CI);
        check_value("decision while sent low", 64'(pulse_count()), 64'(0));
      end
      if (got_port == 1)
      begin
        port1_sent = 1'b1;
      end
      else
      begin
        port2_sent = 1'b1;
      end
      @(negedge Clk_CI);
      check_value("decision after sent", 64'(pulse_count()), 64'(0));
      port1_addr_valid = 1'b0;
      port2_addr_valid = 1'b0;
      @(negedge Clk_CI);
      port1_sent = 1'b0;
      port2_sent = 1'b0;
    end
    else
    begin
      port1_addr_valid = 1'b0;  // drop ends the request on both ports
      port2_addr_valid = 1'b0;
    end
    if (err_count == errs_before)
    begin
      $display("test %0d: pass", idx);
    end
    else
    begin
      tests_failed++;
      $display("test %0d: fail, %0d mismatches", idx, err_count - errs_before);
    end
  endtask

  initial
  begin
    void'($urandom(84854));
    Rst_RBI          = 1'b0;
    port1_addr       = '0;
    port1_len        = '0;
    port1_size       = '0;
    port1_type       = 1'b0;
    port1_addr_valid = 1'b0;
    port1_sent       = 1'b0;
    port2_addr       = '0;
    port2_len        = '0;
    port2_size       = '0;
    port2_type       = 1'b0;
    port2_addr_valid = 1'b0;
    port2_sent       = 1'b0;
    cfg_wen          = 1'b0;
    cfg_addr         = '0;
    cfg_wdata        = '0;
    build_table();
    repeat (2) @(negedge Clk_CI);
    Rst_RBI = 1'b1;
    @(negedge Clk_CI);
    check_value("pulses after reset", 64'(pulse_count()), 64'(0));
    check_value("interrupts after reset", 64'({int_miss, int_prot, int_multi}), 64'(0));
    check_value("out_addr after reset", 64'(port1_out_addr), 64'(0));
    run_test(0);  // first tie while slices are still invalid
    load_slices();
    for (int i = 1; i < N_TESTS; i++)
    begin
      run_test(i);
    end
    @(negedge Clk_CI);
    $display("%0d tests run, %0d failed, %0d mismatches", N_TESTS, tests_failed, err_count);
    if (err_count == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- rab_core.f
rab_pkg.sv
rab_lookup_if.sv
rab_cfg_regs.sv
rab_slice.sv
rab_slice_array.sv
rab_req_arbiter.sv
rab_fsm.sv
rab_core.sv
tb_rab_core.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the rab_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 -Wno-fatal --top-module tb_rab_core -f rab_core.f -o tb_rab_core
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_rab_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" "$LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $LOG"
exit 1
